/* all.f */
+incdir+test
hdl/noc_topo_pkg.sv
hdl/noc_flit_pkg.sv
hdl/flit_fifo.sv
hdl/port_arbiter.sv
hdl/router.sv
hdl/noc_mesh.sv
test/tb_noc_mesh.sv

/* hdl/flit_fifo.sv */
// flit_fifo
// per-input circular flit queue
// head flit shown combinationally, full/empty from an occupancy count

`default_nettype none

module flit_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                 clk_noc,
  input  logic                 reset,
  input  noc_flit_pkg::flit_t  wr_flit,
  input  logic                 wr_en,
  output logic                 full,
  output noc_flit_pkg::flit_t  rd_flit,
  input  logic                 rd_en,
  output logic                 empty
);
  import noc_flit_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0]   FULL_COUNT = (PTR_W + 1)'(DEPTH);

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_wr;
  logic             do_rd;

  // pointer wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  // write while full and read while empty are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full    = (count == FULL_COUNT);
  assign empty   = (count == '0);
  assign rd_flit = mem[rd_ptr];

  always_ff @(posedge clk_noc) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= next_ptr(wr_ptr);
      if (do_rd) rd_ptr <= next_ptr(rd_ptr);
      // simultaneous push and pop keeps the count
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_noc) begin
    if (do_wr) mem[wr_ptr] <= wr_flit;
  end

endmodule

`default_nettype wire

/* hdl/noc_flit_pkg.sv */
// flit format and link definitions
// single-flit packet with destination, source and payload
// forward half of a link, ready runs back as its own bit

`default_nettype none

package noc_flit_pkg;

  // payload bits carried by each flit
  localparam int PAYLOAD_W = 16;

  // 24 bit flit
  // dst first so routing reads the top bits
  typedef struct packed {
    noc_topo_pkg::coord_t   dst;
    noc_topo_pkg::coord_t   src;
    logic [PAYLOAD_W-1:0]   payload;
  } flit_t;

  // forward direction of one link
  // flit only meaningful while valid is high
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

endpackage

`default_nettype wire

/* hdl/noc_mesh.sv */
// noc_mesh
// top level router grid, ROWS by COLS
// neighbour link wiring, local ports to the outside, edge tie-offs
// node number is y + x*COLS

`default_nettype none

module noc_mesh #(
  parameter int ROWS       = 2,
  parameter int COLS       = 2,
  parameter int FIFO_DEPTH = 2
) (
  input  logic                       clk_noc,
  input  logic                       reset,
  input  noc_flit_pkg::link_t        inj       [ROWS*COLS],
  output logic [ROWS*COLS-1:0]       inj_ready,
  output noc_flit_pkg::link_t        ej        [ROWS*COLS],
  input  logic [ROWS*COLS-1:0]       ej_ready
);
  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  // ns travels north, sn south, we west, ew east
  link_t                      ns_link  [(ROWS+1)*COLS];
  link_t                      sn_link  [(ROWS+1)*COLS];
  link_t                      we_link  [ROWS*(COLS+1)];
  link_t                      ew_link  [ROWS*(COLS+1)];
  // ready flows back against each link
  logic [(ROWS+1)*COLS-1:0]   ns_ready;
  logic [(ROWS+1)*COLS-1:0]   sn_ready;
  logic [ROWS*(COLS+1)-1:0]   we_ready;
  logic [ROWS*(COLS+1)-1:0]   ew_ready;

  genvar x;
  genvar y;

  for (x = 0; x < ROWS; x++) begin : g_row
    for (y = 0; y < COLS; y++) begin : g_col
      localparam int LOCAL_IDX = y + x*COLS;
      localparam int NORTH_IDX = y + x*COLS;
      localparam int SOUTH_IDX = y + (x+1)*COLS;
      localparam int WEST_IDX  = y + x*(COLS+1);
      localparam int EAST_IDX  = (y+1) + x*(COLS+1);

      link_t                rin        [NUM_PORTS];
      link_t                rout       [NUM_PORTS];
      logic [NUM_PORTS-1:0] rin_ready;
      logic [NUM_PORTS-1:0] rout_ready;

      router #(
        .ROUTER_X   (x),
        .ROUTER_Y   (y),
        .FIFO_DEPTH (FIFO_DEPTH)
      ) u_router (
        .clk_noc   (clk_noc),
        .reset     (reset),
        .in_link   (rin),
        .in_ready  (rin_ready),
        .out_link  (rout),
        .out_ready (rout_ready)
      );

      // local endpoint
      assign rin[PORT_LOCAL]        = inj[LOCAL_IDX];
      assign inj_ready[LOCAL_IDX]   = rin_ready[PORT_LOCAL];
      assign ej[LOCAL_IDX]          = rout[PORT_LOCAL];
      assign rout_ready[PORT_LOCAL] = ej_ready[LOCAL_IDX];

      // neighbours
      assign rin[PORT_NORTH]        = sn_link[NORTH_IDX];
      assign sn_ready[NORTH_IDX]    = rin_ready[PORT_NORTH];
      assign ns_link[NORTH_IDX]     = rout[PORT_NORTH];
      assign rout_ready[PORT_NORTH] = ns_ready[NORTH_IDX];

      assign rin[PORT_SOUTH]        = ns_link[SOUTH_IDX];
      assign ns_ready[SOUTH_IDX]    = rin_ready[PORT_SOUTH];
      assign sn_link[SOUTH_IDX]     = rout[PORT_SOUTH];
      assign rout_ready[PORT_SOUTH] = sn_ready[SOUTH_IDX];

      assign rin[PORT_WEST]         = ew_link[WEST_IDX];
      assign ew_ready[WEST_IDX]     = rin_ready[PORT_WEST];
      assign we_link[WEST_IDX]      = rout[PORT_WEST];
      assign rout_ready[PORT_WEST]  = we_ready[WEST_IDX];

      assign rin[PORT_EAST]         = we_link[EAST_IDX];
      assign we_ready[EAST_IDX]     = rin_ready[PORT_EAST];
      assign ew_link[EAST_IDX]      = rout[PORT_EAST];
      assign rout_ready[PORT_EAST]  = ew_ready[EAST_IDX];

      // edge tie-offs
      // nothing arrives and nothing is accepted
      if (x == 0) begin : g_north_edge
        assign sn_link[NORTH_IDX]  = '0;
        assign ns_ready[NORTH_IDX] = 1'b0;
      end
      if (x == ROWS-1) begin : g_south_edge
        assign ns_link[SOUTH_IDX]  = '0;
        assign sn_ready[SOUTH_IDX] = 1'b0;
      end
      if (y == 0) begin : g_west_edge
        assign ew_link[WEST_IDX]   = '0;
        assign we_ready[WEST_IDX]  = 1'b0;
      end
      if (y == COLS-1) begin : g_east_edge
        assign we_link[EAST_IDX]   = '0;
        assign ew_ready[EAST_IDX]  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_topo_pkg.sv */
// mesh geometry definitions
// node coordinate type, port count and the router port selector enum
// shared by the routers, the arbiters and the top level grid

`default_nettype none

package noc_topo_pkg;

  // router ports, local plus four neighbours
  localparam int NUM_PORTS = 5;

  // x is the row, y the column
  // 2 bits each, so meshes up to 4 by 4
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } coord_t;

  // indexes port arrays and arbiter request vectors
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_SOUTH = 3'd2,
    PORT_WEST  = 3'd3,
    PORT_EAST  = 3'd4
  } port_e;

endpackage

`default_nettype wire

/* hdl/port_arbiter.sv */
// port_arbiter
// round-robin choice among router inputs for one output port
// grant is combinational, pointer moves only on a granted transfer

`default_nettype none

module port_arbiter (
  input  logic                               clk_noc,
  input  logic                               reset,
  input  logic [noc_topo_pkg::NUM_PORTS-1:0] req,
  input  logic                               out_ready,
  output logic [noc_topo_pkg::NUM_PORTS-1:0] grant
);
  import noc_topo_pkg::*;

  localparam int IDX_W = $clog2(NUM_PORTS);
  // start so that the local port wins first after reset
  localparam logic [IDX_W-1:0] LAST_INIT = IDX_W'(NUM_PORTS - 1);

  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] winner;
  logic             found;
  logic             xfer;

  // search begins just after the last winner
  // last winner itself is checked last
  always_comb begin : search
    int idx;
    found  = 1'b0;
    winner = last_q;
    for (int i = 1; i <= NUM_PORTS; i++) begin
      idx = (int'(last_q) + i) % NUM_PORTS;
      if (!found && req[idx]) begin
        found  = 1'b1;
        winner = IDX_W'(idx);
      end
    end
  end

  // a grant means the flit moves this cycle
  assign xfer  = found && out_ready;
  assign grant = xfer ? (NUM_PORTS'(1) << winner) : '0;

  // pointer held while the output stalls
  // so a blocked winner keeps its turn
  always_ff @(posedge clk_noc) begin
    if (reset) begin
      last_q <= LAST_INIT;
    end else if (xfer) begin
      last_q <= winner;
    end
  end

endmodule

`default_nettype wire

/* hdl/router.sv */
// router
// five-port mesh router with XY routing
// one flit FIFO per input, one round-robin arbiter per output
// route computed at each FIFO head, granted head muxed to the output

`default_nettype none

module router #(
  parameter int ROUTER_X   = 0,
  parameter int ROUTER_Y   = 0,
  parameter int FIFO_DEPTH = 2
) (
  input  logic                               clk_noc,
  input  logic                               reset,
  input  noc_flit_pkg::link_t                in_link  [noc_topo_pkg::NUM_PORTS],
  output logic [noc_topo_pkg::NUM_PORTS-1:0] in_ready,
  output noc_flit_pkg::link_t                out_link [noc_topo_pkg::NUM_PORTS],
  input  logic [noc_topo_pkg::NUM_PORTS-1:0] out_ready
);
  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  // this router's place in the grid
  localparam coord_t HERE = '{x: 2'(ROUTER_X), y: 2'(ROUTER_Y)};

  flit_t                head       [NUM_PORTS];
  port_e                route      [NUM_PORTS];
  logic [NUM_PORTS-1:0] fifo_full;
  logic [NUM_PORTS-1:0] fifo_empty;
  logic [NUM_PORTS-1:0] pop;
  // indexed [output][input]
  logic [NUM_PORTS-1:0] out_req    [NUM_PORTS];
  logic [NUM_PORTS-1:0] out_grant  [NUM_PORTS];

  // dimension order: row first, then column
  function automatic port_e xy_route(coord_t dst);
    port_e sel;
    if (dst.x > HERE.x) begin
      sel = PORT_SOUTH;
    end else if (dst.x < HERE.x) begin
      sel = PORT_NORTH;
    end else if (dst.y > HERE.y) begin
      sel = PORT_EAST;
    end else if (dst.y < HERE.y) begin
      sel = PORT_WEST;
    end else begin
      sel = PORT_LOCAL;
    end
    return sel;
  endfunction

  genvar i;
  genvar o;

  // input side
  for (i = 0; i < NUM_PORTS; i++) begin : g_in
    flit_fifo #(
      .DEPTH(FIFO_DEPTH)
    ) u_fifo (
      .clk_noc (clk_noc),
      .reset   (reset),
      .wr_flit (in_link[i].flit),
      .wr_en   (in_link[i].valid),
      .full    (fifo_full[i]),
      .rd_flit (head[i]),
      .rd_en   (pop[i]),
      .empty   (fifo_empty[i])
    );

    // ready from occupancy only, never from valid
    assign in_ready[i] = !fifo_full[i];
    assign route[i]    = xy_route(head[i].dst);
  end

  // output side
  for (o = 0; o < NUM_PORTS; o++) begin : g_out
    // inputs whose head wants this output
    always_comb begin
      for (int k = 0; k < NUM_PORTS; k++) begin
        out_req[o][k] = !fifo_empty[k] && (route[k] == port_e'(o));
      end
    end

    port_arbiter u_arb (
      .clk_noc   (clk_noc),
      .reset     (reset),
      .req       (out_req[o]),
      .out_ready (out_ready[o]),
      .grant     (out_grant[o])
    );

    // one-hot mux of the granted head
    always_comb begin
      out_link[o].valid = |out_grant[o];
      out_link[o].flit  = '0;
      for (int k = 0; k < NUM_PORTS; k++) begin
        if (out_grant[o][k]) out_link[o].flit = head[k];
      end
    end
  end

  // a head routes to one output, so at most one grant per input
  always_comb begin
    pop = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      pop = pop | out_grant[k];
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the noc_mesh testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_noc_mesh -f all.f -o tb_noc_mesh --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_noc_mesh)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

/* test/tb_cases.svh */
// injection case table for the mesh testbench
// row columns: src node, dst coord (x, y), payload (zero means random filler),
// flit count, offset in cycles before the row starts, ej_ready mask,
// and what to wait for before the next row

`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef enum int {
  THEN_NEXT,   // start the next row right away
  THEN_DRAIN,  // wait until every queued flit came out
  THEN_STALL   // wait for inj_ready low at src, reopen ej, then drain
} settle_e;

typedef struct packed {
  int               src;
  coord_t           dst;
  logic [15:0]      payload;
  int               count;
  int               offset;
  logic [NODES-1:0] ej_mask;
  settle_e          settle;
} case_t;

localparam int NUM_CASES = 20;

localparam case_t CASES [NUM_CASES] = '{
  // point to point, one flit in the mesh at a time
  '{0, '{2'd0, 2'd1}, 16'ha001, 1, 2, 4'hf, THEN_DRAIN},
  '{0, '{2'd1, 2'd0}, 16'ha002, 1, 2, 4'hf, THEN_DRAIN},
  '{0, '{2'd1, 2'd1}, 16'ha003, 1, 2, 4'hf, THEN_DRAIN},
  '{1, '{2'd0, 2'd0}, 16'ha010, 1, 2, 4'hf, THEN_DRAIN},
  '{1, '{2'd1, 2'd0}, 16'ha012, 1, 2, 4'hf, THEN_DRAIN},
  '{1, '{2'd1, 2'd1}, 16'ha013, 1, 2, 4'hf, THEN_DRAIN},
  '{2, '{2'd0, 2'd0}, 16'ha020, 1, 2, 4'hf, THEN_DRAIN},
  '{2, '{2'd0, 2'd1}, 16'ha021, 1, 2, 4'hf, THEN_DRAIN},
  '{2, '{2'd1, 2'd1}, 16'ha023, 1, 2, 4'hf, THEN_DRAIN},
  '{3, '{2'd0, 2'd0}, 16'ha030, 1, 2, 4'hf, THEN_DRAIN},
  '{3, '{2'd0, 2'd1}, 16'ha031, 1, 2, 4'hf, THEN_DRAIN},
  '{3, '{2'd1, 2'd0}, 16'ha032, 1, 2, 4'hf, THEN_DRAIN},
  // self delivery
  '{0, '{2'd0, 2'd0}, 16'h5e00, 1, 2, 4'hf, THEN_DRAIN},
  '{1, '{2'd0, 2'd1}, 16'h5e11, 1, 2, 4'hf, THEN_DRAIN},
  '{2, '{2'd1, 2'd0}, 16'h0000, 1, 2, 4'hf, THEN_DRAIN},
  '{3, '{2'd1, 2'd1}, 16'h5e33, 1, 2, 4'hf, THEN_DRAIN},
  // three sources into node 3 in the same cycles
  '{0, '{2'd1, 2'd1}, 16'hc000, 4, 2, 4'hf, THEN_NEXT},
  '{1, '{2'd1, 2'd1}, 16'hc100, 4, 0, 4'hf, THEN_NEXT},
  '{2, '{2'd1, 2'd1}, 16'h0000, 4, 0, 4'hf, THEN_DRAIN},
  // node 3 closed while node 0 streams toward it
  '{0, '{2'd1, 2'd1}, 16'hb000, 8, 2, 4'b0111, THEN_STALL}
};

`endif

/* test/tb_noc_mesh.sv */
// tb_noc_mesh
// testbench for the 2x2 noc_mesh
// table driven injectors, one per node, and an ejection scoreboard
// compare tasks for flits and single status bits, error count report

`default_nettype none

module tb_noc_mesh;
  timeunit 1ns;
  timeprecision 1ps;

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  localparam int ROWS         = 2;
  localparam int COLS         = 2;
  localparam int NODES        = ROWS * COLS;
  localparam int SEND_CYCLES  = 200;
  localparam int DRAIN_CYCLES = 300;

  `include "tb_cases.svh"

  // flit waiting for its node's injector
  typedef struct packed {
    int    node;
    flit_t flit;
  } pend_t;

  logic             clk_noc;
  logic             reset;
  link_t            inj [NODES];
  logic [NODES-1:0] inj_ready;
  link_t            ej [NODES];
  logic [NODES-1:0] ej_ready;

  pend_t pending_q [$];
  flit_t expected_q [$];
  int    queued_count;
  int    ejected_count;
  int    value_errors;
  int    other_errors;

  noc_mesh #(
    .ROWS       (ROWS),
    .COLS       (COLS),
    .FIFO_DEPTH (2)
  ) DUT (
    .clk_noc   (clk_noc),
    .reset     (reset),
    .inj       (inj),
    .inj_ready (inj_ready),
    .ej        (ej),
    .ej_ready  (ej_ready)
  );

  initial begin
    clk_noc = 1'b0;
    forever #20 clk_noc = ~clk_noc;
  end

  // node number is y + x*COLS
  function automatic coord_t node_coord(int n);
    coord_t c;
    c.x = 2'(n / COLS);
    c.y = 2'(n % COLS);
    return c;
  endfunction

  // oldest pending flit of this node
  function automatic bit take_pending(int node, output flit_t f);
    for (int i = 0; i < pending_q.size(); i++) begin
      if (pending_q[i].node == node) begin
        f = pending_q[i].flit;
        pending_q.delete(i);
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // oldest expected flit for this dst from this src
  function automatic int find_expected(int node, coord_t src);
    coord_t here;
    here = node_coord(node);
    for (int i = 0; i < expected_q.size(); i++) begin
      if (expected_q[i].dst == here && expected_q[i].src == src) return i;
    end
    return -1;
  endfunction

  task automatic check_flit(flit_t exp, flit_t act, string name);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("  fields exp/got: dst %h/%h src %h/%h payload %h/%h",
               exp.dst, act.dst, exp.src, act.src, exp.payload, act.payload);
      value_errors++;
    end
  endtask

  task automatic check_bit(logic exp, logic act, string name);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  // hand a row's flits to the injector, expected copies to the scoreboard
  task automatic queue_row(case_t row);
    pend_t p;
    for (int k = 0; k < row.count; k++) begin
      p.node     = row.src;
      p.flit.dst = row.dst;
      p.flit.src = node_coord(row.src);
      if (row.payload == '0) p.flit.payload = 16'($urandom());
      else p.flit.payload = row.payload + 16'(k);
      pending_q.push_back(p);
      expected_q.push_back(p.flit);
      queued_count++;
    end
  endtask

  task automatic wait_drain(int row);
    int waited;
    waited = 0;
    while (ejected_count != queued_count && waited < DRAIN_CYCLES) begin
      @(negedge clk_noc);
      waited++;
    end
    if (ejected_count != queued_count) begin
      $display("%0t ns: after row %0d, %0d flits still missing after %0d cycles",
               $time, row, queued_count - ejected_count, DRAIN_CYCLES);
      other_errors++;
    end
  endtask

  // back-pressure must reach the source
  task automatic wait_stall(int node);
    int waited;
    waited = 0;
    while (inj_ready[node] && waited < DRAIN_CYCLES) begin
      @(negedge clk_noc);
      waited++;
    end
    if (inj_ready[node]) begin
      $display("%0t ns: inj_ready at node %0d never dropped while its target was stalled",
               $time, node);
      other_errors++;
    end
  endtask

  // one injector per node
  for (genvar g = 0; g < NODES; g++) begin : g_inj
    link_t drive;

    assign inj[g] = drive;

    initial begin : injector
      flit_t f;
      int    waited;
      bit    accepted;
      drive = '0;
      forever begin
        if (take_pending(g, f)) begin
          @(negedge clk_noc);
          drive.flit  = f;
          drive.valid = 1'b1;
          waited      = 0;
          accepted    = 1'b0;
          // transfer on the edge where ready is high
          while (!accepted && waited < SEND_CYCLES) begin
            @(posedge clk_noc);
            if (inj_ready[g]) accepted = 1'b1;
            else waited++;
          end
          if (!accepted) begin
            $display("%0t ns: node %0d gave up on a flit, inj_ready stayed low %0d cycles",
                     $time, g, SEND_CYCLES);
            other_errors++;
          end
        end else begin
          @(negedge clk_noc);
          drive.valid = 1'b0;
          @(posedge clk_noc);
        end
      end
    end
  end

  // ejection scoreboard
  always @(posedge clk_noc) begin : eject_monitor
    flit_t got;
    int    hit;
    if (!reset) begin
      for (int n = 0; n < NODES; n++) begin
        if (ej[n].valid && ej_ready[n]) begin
          got = ej[n].flit;
          hit = find_expected(n, got.src);
          if (hit < 0) begin
            $display("%0t ns: node %0d ejected a flit from (%0d,%0d) that was never sent there",
                     $time, n, got.src.x, got.src.y);
            other_errors++;
          end else begin
            check_flit(expected_q[hit], got, $sformatf("ej[%0d].flit", n));
            expected_q.delete(hit);
            ejected_count++;
          end
        end
      end
    end
  end

  initial begin : main_seq
    void'($urandom(24375));
    queued_count  = 0;
    ejected_count = 0;
    value_errors  = 0;
    other_errors  = 0;
    reset         = 1'b1;
    ej_ready      = '1;
    repeat (4) @(posedge clk_noc);
    @(negedge clk_noc);
    reset = 1'b0;

    // reset status, first cycle out of reset
    @(negedge clk_noc);
    for (int n = 0; n < NODES; n++) begin
      check_bit(1'b0, ej[n].valid, $sformatf("ej[%0d].valid", n));
      check_bit(1'b1, inj_ready[n], $sformatf("inj_ready[%0d]", n));
    end

    for (int r = 0; r < NUM_CASES; r++) begin
      repeat (CASES[r].offset) @(negedge clk_noc);
      ej_ready = CASES[r].ej_mask;
      queue_row(CASES[r]);
      case (CASES[r].settle)
        THEN_DRAIN: wait_drain(r);
        THEN_STALL: begin
          wait_stall(CASES[r].src);
          ej_ready = '1;
          wait_drain(r);
        end
        default: ;
      endcase
    end

    wait_drain(NUM_CASES);
    $display("error count: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
